// ==== include/sine_table.svh ====
`ifndef SINE_TABLE_SVH
`define SINE_TABLE_SVH
// First quadrant of a 256-point sine, amplitude 0x3fff
localparam lfo_t SINE_PEAK = 16'sh3fff;
localparam lfo_t SINE_QUARTER [0:63] = '{
	16'sh0000,
	16'sh0192,
	16'sh0323,
	16'sh04b5,
	16'sh0645,
	16'sh07d5,
	16'sh0963,
	16'sh0af0,
	16'sh0c7c,
	16'sh0e05,
	16'sh0f8c,
	16'sh1111,
	16'sh1293,
	16'sh1413,
	16'sh158f,
	16'sh1708,
	16'sh187d,
	16'sh19ef,
	16'sh1b5c,
	16'sh1cc5,
	16'sh1e2a,
	16'sh1f8b,
	16'sh20e6,
	16'sh223c,
	16'sh238d,
	16'sh24d9,
	16'sh261f,
	16'sh275f,
	16'sh2899,
	16'sh29cc,
	16'sh2afa,
	16'sh2c20,
	16'sh2d40,
	16'sh2e59,
	16'sh2f6b,
	16'sh3075,
	16'sh3178,
	16'sh3273,
	16'sh3366,
	16'sh3452,
	16'sh3535,
	16'sh3611,
	16'sh36e4,
	16'sh37ae,
	16'sh3870,
	16'sh3929,
	16'sh39da,
	16'sh3a81,
	16'sh3b1f,
	16'sh3bb5,
	16'sh3c41,
	16'sh3cc4,
	16'sh3d3d,
	16'sh3dad,
	16'sh3e14,
	16'sh3e70,
	16'sh3ec4,
	16'sh3f0d,
	16'sh3f4d,
	16'sh3f83,
	16'sh3fb0,
	16'sh3fd2,
	16'sh3feb,
	16'sh3ffa
};
`endif

// ==== rtl/amp_pkg.sv ====
package amp_pkg;

	// Mono audio sample
	localparam int SAMPLE_W = 24;
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Saturation limits of a 24-bit signed sample
	localparam int SAMPLE_MAX = 8_388_607;
	localparam int SAMPLE_MIN = -8_388_608;

	// Gain in hundredths of unity
	localparam int GAIN_W = 10;
	typedef logic [GAIN_W-1:0] gain_t;
	localparam gain_t GAIN_UNITY = 10'd100;
	localparam gain_t GAIN_STEP = 10'd10;
	localparam gain_t GAIN_MAX = 10'd1000;
	localparam int GAIN_DIVISOR = 100;

	// Sample times gain, one spare bit for the sign of the gain operand
	typedef logic signed [SAMPLE_W+GAIN_W:0] product_t;

	// Overdrive clip magnitude
	localparam int DRIVE_LEVEL = 6_000_000;

	// Button repeat, half a second at 50 MHz
	localparam int GAIN_REPEAT_CYCLES = 25_000_000;

	// Tremolo oscillator
	localparam int LFO_ADDR_W = 8;
	localparam int LFO_SAMPLES_PER_STEP = 4;
	typedef logic signed [15:0] lfo_t;

	// Lifts the sine above zero, factor range 1 to 32767
	localparam lfo_t LFO_OFFSET = 16'sd16384;
	localparam int LFO_SHIFT = 15;

endpackage

// ==== rtl/pipe_slice.sv ====
`timescale 1ns/1ps

module pipe_slice #(
	parameter type T = logic
) (
	input  logic CLOCK_50,
	input  logic resetn,
	input  logic up_valid,
	output logic up_ready,
	input  T     up_data,
	output logic dn_valid,
	input  logic dn_ready,
	output T     dn_data
);

	// Accept when empty or when the held entry leaves this cycle
	assign up_ready = !dn_valid || dn_ready;

	// Valid flag
	always_ff @(posedge CLOCK_50) begin
		if (resetn) begin
			dn_valid <= 1'b0;
		end else if (up_ready) begin
			dn_valid <= up_valid;
		end
	end

	// Payload register, loads only on a transfer
	always_ff @(posedge CLOCK_50) begin
		if (up_valid && up_ready) begin
			dn_data <= up_data;
		end
	end

	// Stalled output holds both flag and payload
	a_hold_stable: assert property (@(posedge CLOCK_50) disable iff (resetn)
		(dn_valid && !dn_ready) |=> (dn_valid && $stable(dn_data)))
		else $error("slice output changed while stalled");

endmodule

// ==== rtl/amp_control.sv ====
`timescale 1ns/1ps

module amp_control
	import amp_pkg::*;
#(
	parameter int REPEAT_CYCLES = GAIN_REPEAT_CYCLES
) (
	input  logic  CLOCK_50,
	input  logic  resetn,
	input  logic  gain_up,
	input  logic  gain_down,
	input  logic  overdrive_sw,
	input  logic  tremolo_sw,
	output gain_t gain,
	output logic  overdrive_en,
	output logic  tremolo_en
);

	// Bit order: up, down, overdrive, tremolo
	logic [3:0] sync_a;
	logic [3:0] sync_b;
	logic up_s;
	logic down_s;
	logic step_hold;
	logic [$clog2(REPEAT_CYCLES+1)-1:0] rep_cnt;

	// Two-flop synchronizers for buttons and switches
	always_ff @(posedge CLOCK_50) begin
		if (resetn) begin
			sync_a <= '0;
			sync_b <= '0;
		end else begin
			sync_a <= {tremolo_sw, overdrive_sw, gain_down, gain_up};
			sync_b <= sync_a;
		end
	end

	assign up_s = sync_b[0];
	assign down_s = sync_b[1];
	assign overdrive_en = sync_b[2];
	assign tremolo_en = sync_b[3];

	// Exactly one button held
	assign step_hold = up_s ^ down_s;

	// Step on first held cycle, then once per repeat period
	always_ff @(posedge CLOCK_50) begin
		if (resetn) begin
			gain <= GAIN_UNITY;
			rep_cnt <= '0;
		end else if (!step_hold) begin
			rep_cnt <= '0;
		end else if (rep_cnt == '0) begin
			rep_cnt <= ($clog2(REPEAT_CYCLES+1))'(REPEAT_CYCLES - 1);
			// Saturate at the ends of the range
			if (up_s && (gain <= GAIN_MAX - GAIN_STEP)) begin
				gain <= gain + GAIN_STEP;
			end else if (down_s && (gain >= GAIN_STEP)) begin
				gain <= gain - GAIN_STEP;
			end
		end else begin
			rep_cnt <= rep_cnt - 1'b1;
		end
	end

	// Gain stays on the 10-step grid inside 0..1000
	a_gain_range: assert property (@(posedge CLOCK_50) disable iff (resetn)
		(gain <= GAIN_MAX) && ((gain % GAIN_STEP) == 0))
		else $error("gain register left its range or step grid: %0d", gain);

endmodule

// ==== rtl/gain_drive_stage.sv ====
`timescale 1ns/1ps

module gain_drive_stage
	import amp_pkg::*;
(
	input  logic    CLOCK_50,
	input  logic    resetn,
	input  logic    in_valid,
	output logic    in_ready,
	input  sample_t in_sample,
	input  gain_t   gain,
	input  logic    overdrive_en,
	output logic    out_valid,
	input  logic    out_ready,
	output sample_t out_sample
);

	product_t prod_in;
	product_t prod_q;
	logic prod_valid;
	logic prod_ready;
	product_t prod_div;
	sample_t sat;
	sample_t clipped;

	// Gain treated as a positive signed operand
	assign prod_in = in_sample * $signed({1'b0, gain});

	// Slice 1 holds the raw product
	pipe_slice #(
		.T(product_t)
	) u_prod_slice (
		.CLOCK_50 (CLOCK_50),
		.resetn   (resetn),
		.up_valid (in_valid),
		.up_ready (in_ready),
		.up_data  (prod_in),
		.dn_valid (prod_valid),
		.dn_ready (prod_ready),
		.dn_data  (prod_q)
	);

	always_comb begin
		// Signed divide truncates toward zero
		prod_div = prod_q / GAIN_DIVISOR;

		// Saturate to 24-bit range
		if (prod_div > SAMPLE_MAX) begin
			sat = sample_t'(SAMPLE_MAX);
		end else if (prod_div < SAMPLE_MIN) begin
			sat = sample_t'(SAMPLE_MIN);
		end else begin
			sat = sample_t'(prod_div);
		end

		// Hard clip at the drive level
		if (overdrive_en && (sat > DRIVE_LEVEL)) begin
			clipped = sample_t'(DRIVE_LEVEL);
		end else if (overdrive_en && (sat < -DRIVE_LEVEL)) begin
			clipped = sample_t'(-DRIVE_LEVEL);
		end else begin
			clipped = sat;
		end
	end

	// Slice 2 holds the scaled and clipped sample
	pipe_slice #(
		.T(sample_t)
	) u_clip_slice (
		.CLOCK_50 (CLOCK_50),
		.resetn   (resetn),
		.up_valid (prod_valid),
		.up_ready (prod_ready),
		.up_data  (clipped),
		.dn_valid (out_valid),
		.dn_ready (out_ready),
		.dn_data  (out_sample)
	);

endmodule

// ==== rtl/tremolo_stage.sv ====
`timescale 1ns/1ps

module tremolo_stage
	import amp_pkg::*;
(
	input  logic    CLOCK_50,
	input  logic    resetn,
	input  logic    in_valid,
	output logic    in_ready,
	input  sample_t in_sample,
	input  logic    tremolo_en,
	output logic    out_valid,
	input  logic    out_ready,
	output sample_t out_sample
);

	`include "sine_table.svh"

	logic [$clog2(LFO_SAMPLES_PER_STEP)-1:0] step_cnt;
	logic [LFO_ADDR_W-1:0] phase;
	logic [LFO_ADDR_W-3:0] quad_idx;
	logic accept;
	lfo_t quarter_val;
	lfo_t sine_val;
	lfo_t lfo_factor;
	logic signed [SAMPLE_W+$bits(lfo_t)-1:0] trem_prod;
	sample_t scaled;

	assign accept = in_valid && in_ready;

	// Phase advances once per group of accepted samples
	always_ff @(posedge CLOCK_50) begin
		if (resetn) begin
			step_cnt <= '0;
			phase <= '0;
		end else if (accept) begin
			if (step_cnt == LFO_SAMPLES_PER_STEP - 1) begin
				step_cnt <= '0;
				// Wraps after 256 phases
				phase <= phase + 1'b1;
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end
		end
	end

	// Falling quadrants read the table backwards
	assign quad_idx = phase[LFO_ADDR_W-2] ? (~phase[LFO_ADDR_W-3:0] + 1'b1)
		: phase[LFO_ADDR_W-3:0];

	always_comb begin
		// Peak sits one past the end of the quarter table
		if (phase[LFO_ADDR_W-2] && (phase[LFO_ADDR_W-3:0] == '0)) begin
			quarter_val = SINE_PEAK;
		end else begin
			quarter_val = SINE_QUARTER[quad_idx];
		end
		// Second half is the negated first half
		sine_val = phase[LFO_ADDR_W-1] ? -quarter_val : quarter_val;
		lfo_factor = sine_val + LFO_OFFSET;
	end

	// Factor is positive, so the shifted product fits a sample
	assign trem_prod = in_sample * lfo_factor;
	assign scaled = tremolo_en ? sample_t'(trem_prod >>> LFO_SHIFT) : in_sample;

	pipe_slice #(
		.T(sample_t)
	) u_trem_slice (
		.CLOCK_50 (CLOCK_50),
		.resetn   (resetn),
		.up_valid (in_valid),
		.up_ready (in_ready),
		.up_data  (scaled),
		.dn_valid (out_valid),
		.dn_ready (out_ready),
		.dn_data  (out_sample)
	);

	// Zero factor would silence the signal
	a_factor_nonzero: assert property (@(posedge CLOCK_50) disable iff (resetn)
		lfo_factor != '0)
		else $error("tremolo factor is zero at phase %0d", phase);

endmodule

// ==== rtl/guitar_amp_core.sv ====
`timescale 1ns/1ps

module guitar_amp_core
	import amp_pkg::*;
#(
	parameter int REPEAT_CYCLES = GAIN_REPEAT_CYCLES
) (
	input  logic    CLOCK_50,
	input  logic    resetn,
	// Sample stream in
	input  logic    in_valid,
	output logic    in_ready,
	input  sample_t in_sample,
	// Sample stream out
	output logic    out_valid,
	input  logic    out_ready,
	output sample_t out_sample,
	// Buttons and switches, asynchronous
	input  logic    gain_up,
	input  logic    gain_down,
	input  logic    overdrive_sw,
	input  logic    tremolo_sw,
	output gain_t   gain_level
);

	gain_t gain;
	logic overdrive_en;
	logic tremolo_en;
	logic mid_valid;
	logic mid_ready;
	sample_t mid_sample;

	assign gain_level = gain;

	// Controls steering both stages
	amp_control #(
		.REPEAT_CYCLES(REPEAT_CYCLES)
	) u_amp_control (
		.CLOCK_50     (CLOCK_50),
		.resetn       (resetn),
		.gain_up      (gain_up),
		.gain_down    (gain_down),
		.overdrive_sw (overdrive_sw),
		.tremolo_sw   (tremolo_sw),
		.gain         (gain),
		.overdrive_en (overdrive_en),
		.tremolo_en   (tremolo_en)
	);

	// Two cycles of gain and clip
	gain_drive_stage u_gain_drive_stage (
		.CLOCK_50     (CLOCK_50),
		.resetn       (resetn),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_sample    (in_sample),
		.gain         (gain),
		.overdrive_en (overdrive_en),
		.out_valid    (mid_valid),
		.out_ready    (mid_ready),
		.out_sample   (mid_sample)
	);

	// One cycle of tremolo
	tremolo_stage u_tremolo_stage (
		.CLOCK_50   (CLOCK_50),
		.resetn     (resetn),
		.in_valid   (mid_valid),
		.in_ready   (mid_ready),
		.in_sample  (mid_sample),
		.tremolo_en (tremolo_en),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_sample (out_sample)
	);

endmodule

// ==== bench/amp_checker.sv ====
`timescale 1ns/1ps

module amp_checker
	import amp_pkg::*;
(
	input  logic    CLOCK_50,
	input  logic    resetn,
	input  logic    in_valid,
	input  logic    in_ready,
	input  sample_t exp_sample,
	input  logic    out_valid,
	input  logic    out_ready,
	input  sample_t out_sample,
	input  logic    gain_up,
	input  logic    gain_down,
	input  gain_t   gain_level,
	input  int      test_num,
	input  logic    test_done,
	input  logic    report,
	output int      pending,
	output int      tests_failed
);

	sample_t exp_q [$];
	sample_t want;
	gain_t prev_gain, want_gain;
	int last_dir, errors, tests_run;
	logic reset_seen;

	function automatic string test_name(input int n);
		case (n)
			1: return "reset state";
			2: return "unity pass-through";
			3: return "gain control";
			4: return "saturation and overdrive";
			5: return "tremolo";
			6: return "back-pressure";
			default: return "unnamed";
		endcase
	endfunction

	initial begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		pending = 0;
	end

	always @(posedge CLOCK_50) begin
		if (resetn) begin
			exp_q.delete();
			prev_gain = GAIN_UNITY;
			last_dir = 0;
			reset_seen = 1'b0;
		end else begin
			// First cycle out of reset
			if (!reset_seen) begin
				reset_seen = 1'b1;
				if (out_valid !== 1'b0) begin
					$display("mismatch out_valid: got %h expected %h", out_valid, 1'b0);
					errors++;
				end
				if (in_ready !== 1'b1) begin
					$display("mismatch in_ready: got %h expected %h", in_ready, 1'b1);
					errors++;
				end
				if (gain_level !== GAIN_UNITY) begin
					$display("mismatch gain_level: got %h expected %h", gain_level, GAIN_UNITY);
					errors++;
				end
			end
			// Expected value travels with the accepted input
			if (in_valid && in_ready) begin
				exp_q.push_back(exp_sample);
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("output sample %h arrived with no sample expected", out_sample);
					errors++;
				end else begin
					want = exp_q.pop_front();
					if (out_sample !== want) begin
						$display("mismatch out_sample: got %h expected %h", out_sample, want);
						errors++;
					end
				end
			end
			// Direction of the latest single-button press
			if (gain_up && !gain_down) begin
				last_dir = 1;
			end else if (gain_down && !gain_up) begin
				last_dir = -1;
			end
			if (gain_level !== prev_gain) begin
				want_gain = (last_dir > 0) ? prev_gain + GAIN_STEP : prev_gain - GAIN_STEP;
				if (last_dir == 0) begin
					$display("gain_level changed although no button was pressed");
					errors++;
				end else if (gain_level !== want_gain) begin
					$display("mismatch gain_level: got %h expected %h", gain_level, want_gain);
					errors++;
				end
				if (gain_level > GAIN_MAX) begin
					$display("gain_level went above the upper limit of 1000");
					errors++;
				end
				prev_gain = gain_level;
			end
			if (test_done) begin
				tests_run++;
				if (errors == 0) begin
					$display("test %0d %s: pass", test_num, test_name(test_num));
				end else begin
					$display("test %0d %s: fail, %0d errors", test_num, test_name(test_num), errors);
					tests_failed++;
				end
				errors = 0;
			end
			if (report) begin
				$display("tests run %0d, passed %0d, failed %0d", tests_run,
					tests_run - tests_failed, tests_failed);
			end
		end
		pending <= exp_q.size();
	end

endmodule

// ==== bench/tb_guitar_amp.sv ====
`timescale 1ns/1ps

module tb_guitar_amp
	import amp_pkg::*;
();

	localparam int TB_REPEAT = 16;
	localparam int VEC_LINES = 26;
	localparam int WAIT_LIMIT = 4000;

	logic CLOCK_50, resetn;
	logic in_valid, in_ready, out_valid, out_ready;
	sample_t in_sample, exp_sample, out_sample;
	logic gain_up, gain_down, overdrive_sw, tremolo_sw;
	gain_t gain_level;
	logic test_done, report, bp_on, aborted;
	int test_num, pending, tests_failed;
	// Five hex words per vector line
	logic [31:0] vec_mem [0:VEC_LINES*5-1];

	guitar_amp_core #(.REPEAT_CYCLES(TB_REPEAT)) u_guitar_amp_core (.*);
	amp_checker u_amp_checker (.*);

	always #2 CLOCK_50 = ~CLOCK_50;

	// Random output stall during the back-pressure test
	initial begin
		void'($urandom(32'h6ed3_c4b3));
		forever begin
			@(posedge CLOCK_50);
			out_ready <= bp_on ? ($urandom % 2 == 1) : 1'b1;
		end
	end

	task automatic wait_cycles(input int n);
		for (int k = 0; k < n; k++) begin
			@(posedge CLOCK_50);
		end
	endtask

	task automatic send_sample(input sample_t s, input sample_t e);
		int t;
		t = 0;
		in_valid <= 1'b1;
		in_sample <= s;
		exp_sample <= e;
		@(posedge CLOCK_50);
		while (!in_ready && !aborted) begin
			t++;
			if (t > WAIT_LIMIT) begin
				aborted = 1'b1;
				$display("timeout: in_ready stayed low and the sample was never accepted");
			end else begin
				@(posedge CLOCK_50);
			end
		end
	endtask

	// Stop input and wait for every expected sample to come out
	task automatic drain();
		int t;
		t = 0;
		in_valid <= 1'b0;
		@(posedge CLOCK_50);
		while ((pending != 0) && !aborted) begin
			t++;
			if (t > WAIT_LIMIT) begin
				aborted = 1'b1;
				$display("timeout: %0d expected samples never arrived", pending);
			end else begin
				@(posedge CLOCK_50);
			end
		end
	endtask

	task automatic set_gain(input gain_t target);
		int t;
		t = 0;
		while ((gain_level != target) && !aborted) begin
			gain_up <= (gain_level < target);
			gain_down <= (gain_level > target);
			@(posedge CLOCK_50);
			t++;
			if (t > WAIT_LIMIT) begin
				aborted = 1'b1;
				$display("timeout: gain_level stuck at %0d on the way to %0d", gain_level, target);
			end
		end
		// Keep pushing at either end of the range
		if ((target == GAIN_MAX) || (target == '0)) begin
			wait_cycles(3 * TB_REPEAT);
		end
		gain_up <= 1'b0;
		gain_down <= 1'b0;
	endtask

	task automatic apply_config(input logic od, input logic trem, input gain_t g);
		if ((od != overdrive_sw) || (trem != tremolo_sw) || (g != gain_level)) begin
			drain();
			overdrive_sw <= od;
			tremolo_sw <= trem;
			set_gain(g);
			// Two synchronizer flops plus margin
			wait_cycles(4);
		end
	endtask

	task automatic run_line(input int i);
		if (!aborted) begin
			apply_config(vec_mem[i*5][0], vec_mem[i*5+1][0], vec_mem[i*5+2][GAIN_W-1:0]);
			send_sample(vec_mem[i*5+3][SAMPLE_W-1:0], vec_mem[i*5+4][SAMPLE_W-1:0]);
		end
	endtask

	task automatic end_test();
		drain();
		if (!aborted) begin
			test_done <= 1'b1;
			@(posedge CLOCK_50);
			test_done <= 1'b0;
		end
	endtask

	// Test number of each line in the vector file
	function automatic int test_of_line(input int line);
		if (line < 4) begin
			return 2;
		end else if (line < 10) begin
			return 3;
		end else if (line < 18) begin
			return 4;
		end
		return 5;
	endfunction

	initial begin
		int cur_test;
		CLOCK_50 = 1'b0;
		resetn = 1'b1;
		in_valid = 1'b0;
		in_sample = '0;
		exp_sample = '0;
		out_ready = 1'b1;
		gain_up = 1'b0;
		gain_down = 1'b0;
		overdrive_sw = 1'b0;
		tremolo_sw = 1'b0;
		test_num = 1;
		test_done = 1'b0;
		report = 1'b0;
		bp_on = 1'b0;
		aborted = 1'b0;
		$readmemh("bench/amp_vectors.txt", vec_mem);
		if ($isunknown(vec_mem[VEC_LINES*5-1])) begin
			aborted = 1'b1;
			$display("vector file bench/amp_vectors.txt could not be read in full");
		end
		wait_cycles(8);
		resetn <= 1'b0;
		wait_cycles(2);
		end_test();
		cur_test = 2;
		test_num <= cur_test;
		for (int i = 0; i < VEC_LINES; i++) begin
			if (test_of_line(i) != cur_test) begin
				end_test();
				cur_test = test_of_line(i);
				test_num <= cur_test;
			end
			run_line(i);
		end
		end_test();
		// Replay every line without tremolo under random stalls
		test_num <= 6;
		bp_on <= 1'b1;
		for (int i = 0; i < VEC_LINES; i++) begin
			if (vec_mem[i*5+1][0] == 1'b0) begin
				run_line(i);
			end
		end
		end_test();
		bp_on <= 1'b0;
		report <= 1'b1;
		wait_cycles(1);
		report <= 1'b0;
		wait_cycles(2);
		if (aborted || (tests_failed != 0)) begin
			$display("SOME TESTS FAILED");
		end else begin
			$display("ALL TESTS PASSED");
		end
		$finish;
	end

endmodule

// ==== guitar_amp.f ====
+incdir+include
rtl/amp_pkg.sv
rtl/pipe_slice.sv
rtl/amp_control.sv
rtl/gain_drive_stage.sv
rtl/tremolo_stage.sv
rtl/guitar_amp_core.sv
bench/amp_checker.sv
bench/tb_guitar_amp.sv

// ==== bench/amp_vectors.txt ====
// overdrive tremolo gain sample expected, all hex
// samples are 24-bit two's complement, gain in hundredths
0 0 064 000001 000001
0 0 064 123456 123456
0 0 064 ffffff ffffff
0 0 064 800000 800000
0 0 3e8 000064 0003e8
0 0 3e8 fffff6 ffff9c
0 0 000 7fffff 000000
0 0 000 800000 000000
0 0 0fa 001000 002800
0 0 0fa fffffd fffff9
0 0 3e8 100000 7fffff
0 0 3e8 f00000 800000
1 0 3e8 100000 5b8d80
1 0 3e8 f00000 a47280
1 0 064 5b8d80 5b8d80
1 0 064 5b8d81 5b8d80
1 0 064 a47280 a47280
1 0 064 0abcde 0abcde
0 1 064 008000 004645
0 1 064 ff8000 ffb9bb
0 1 064 100000 08faa0
0 1 064 000001 000000
0 1 064 ffffff ffffff
0 1 064 7fffff 47d4ff
0 1 064 800000 b69d00
0 1 064 000100 000092
